//--- Bender.yml
package:
  name: lsu

sources:
  - lsu_pkg.sv
  - lsu_txn_if.sv
  - lsu_rsp_if.sv
  - lsu_req_stage.sv
  - lsu_txn_tracker.sv
  - lsu_rdata_align.sv
  - lsu_top.sv
  - target: simulation
    files:
      - tb_lsu_top.sv

//--- lsu_pkg.sv
package lsu_pkg;

  ////////////////////
  // Basic widths
  ////////////////////

  typedef logic [31:0] addr_t;   // Byte address
  typedef logic [31:0] data_t;   // One data word
  typedef logic [3:0]  be_t;     // One enable per byte lane
  typedef logic [1:0]  offset_t; // Byte offset within a word

  localparam int unsigned BYTES_PER_WORD = 4; // Byte lanes on the data bus

  // Access size of a load or store
  typedef enum logic [1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10
  } lsu_size_e;

  ////////////////////
  // Byte enables
  ////////////////////

  // Base patterns at offset 0, shifted by the address offset
  localparam be_t BE_BYTE = 4'b0001;
  localparam be_t BE_HALF = 4'b0011;
  localparam be_t BE_WORD = 4'b1111;

  // Per-transfer control needed when rvalid comes back
  typedef struct packed {
    logic      we;       // Store
    lsu_size_e size;     // Access size
    logic      sign_ext; // Sign extend load result
    offset_t   offset;   // Offset of the original address
    logic      last;     // Final transfer of the access
  } lsu_ctrl_t;

endpackage

//--- lsu_rdata_align.sv
`timescale 1ns/1ps

module lsu_rdata_align import lsu_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  output logic   resp_valid_o,
  output data_t  resp_rdata_o,
  output logic   resp_err_o,
  lsu_rsp_if.dst rsp
);

  localparam int unsigned BYTE_W = $bits(data_t) / BYTES_PER_WORD;

  data_t                      hold_q;   // First half of a split load
  logic                       err_q;    // Sticky error of the first phase
  logic                       split;
  data_t                      src_lo;
  logic [2*$bits(data_t)-1:0] pair_sh;
  data_t                      aligned;
  data_t                      ext;

  ////////////////////
  // First phase
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (rsp.valid && !rsp.ctrl.last && !rsp.ctrl.we)
      hold_q <= rsp.rdata; // Raw word, merged later
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      err_q <= 1'b0;
    else if (rsp.valid)
      err_q <= !rsp.ctrl.last && rsp.err; // Cleared by the last phase
  end

  // Same split rule as the request side
  assign split = (rsp.ctrl.offset != 2'd0) &&
                 ((rsp.ctrl.size == LSU_WORD) ||
                  ((rsp.ctrl.size == LSU_HALF) && (rsp.ctrl.offset == 2'd3)));

  ////////////////////
  // Merge and extend
  ////////////////////

  // Split: held upper lanes below new lower lanes. Else a plain rotate
  assign src_lo  = split ? hold_q : rsp.rdata;
  assign pair_sh = {rsp.rdata, src_lo} >> (BYTE_W * rsp.ctrl.offset);
  assign aligned = pair_sh[$bits(data_t)-1:0];

  always_comb
  begin
    case (rsp.ctrl.size)
      LSU_BYTE: ext = {{24{rsp.ctrl.sign_ext & aligned[7]}}, aligned[7:0]};
      LSU_HALF: ext = {{16{rsp.ctrl.sign_ext & aligned[15]}}, aligned[15:0]};
      default:  ext = aligned;
    endcase
  end

  assign resp_valid_o = rsp.valid && rsp.ctrl.last;
  assign resp_rdata_o = rsp.ctrl.we ? '0 : ext;           // Stores return zero
  assign resp_err_o   = resp_valid_o && (rsp.err || err_q); // Either phase

  // A first phase only comes from an access that the request side split
  a_first_phase_split : assert property (@(posedge clk) disable iff (!rst_n)
    rsp.valid && !rsp.ctrl.last |-> split);

endmodule

//--- lsu_req_stage.sv
`timescale 1ns/1ps

module lsu_req_stage import lsu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  // Request side
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  logic      req_we_i,
  input  lsu_size_e req_size_i,
  input  logic      req_sign_ext_i,
  input  addr_t     req_addr_i,
  input  data_t     req_wdata_i,
  // Bus request side
  output logic      data_req_o,
  input  logic      data_gnt_i,
  output addr_t     data_addr_o,
  output logic      data_we_o,
  output be_t       data_be_o,
  output data_t     data_wdata_o,
  // To the tracker
  lsu_txn_if.src    txn
);

  localparam int unsigned BYTE_W = $bits(data_t) / BYTES_PER_WORD;

  logic      busy_q;     // Holds an access
  logic      phase_q;    // 0 first phase, 1 second phase of a split
  addr_t     addr_q;
  logic      we_q;
  lsu_size_e size_q;
  logic      sign_ext_q;
  data_t     wdata_q;    // Unrotated store operand

  offset_t                       offset;
  logic                          misaligned;
  logic                          last_phase;
  logic                          accept;
  logic                          grant;
  be_t                           be_base;
  logic [2*BYTES_PER_WORD-1:0]   be_span;   // Lanes of both phases

  assign offset = addr_q[1:0];
  assign accept = req_valid_i && req_ready_o;
  assign grant  = data_req_o && data_gnt_i;

  // Word off any boundary, or halfword crossing into the next word
  assign misaligned = ((size_q == LSU_WORD) && (offset != 2'd0)) ||
                      ((size_q == LSU_HALF) && (offset == 2'd3));
  assign last_phase = !misaligned || phase_q;

  ////////////////////
  // Sequencing
  ////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy_q  <= 1'b0;
      phase_q <= 1'b0;
    end
    else if (accept)
    begin
      busy_q  <= 1'b1;
      phase_q <= 1'b0;
    end
    else if (grant)
    begin
      busy_q  <= !last_phase;  // Done after last grant
      phase_q <= !last_phase;
    end
  end

  // Access payload, only taken on acceptance
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      addr_q     <= req_addr_i;
      we_q       <= req_we_i;
      size_q     <= req_size_i;
      sign_ext_q <= req_sign_ext_i;
      wdata_q    <= req_wdata_i;
    end
  end

  assign req_ready_o = !busy_q;
  assign data_req_o  = busy_q && txn.room; // Never overfill the tracker

  ////////////////////
  // Bus fields
  ////////////////////

  // Second phase always starts at lane 0 of the next word
  assign data_addr_o = phase_q ? ({addr_q[31:2], 2'b00} + addr_t'(BYTES_PER_WORD)) : addr_q;
  assign data_we_o   = we_q;

  always_comb
  begin
    case (size_q)
      LSU_BYTE: be_base = BE_BYTE;
      LSU_HALF: be_base = BE_HALF;
      default:  be_base = BE_WORD;
    endcase
  end

  // Upper half of the span spills into the next word
  assign be_span   = {{BYTES_PER_WORD{1'b0}}, be_base} << offset;
  assign data_be_o = phase_q ? be_span[2*BYTES_PER_WORD-1:BYTES_PER_WORD]
                             : be_span[BYTES_PER_WORD-1:0];

  // Operand byte i goes to lane (i + offset) mod 4, same word on both phases
  always_comb
  begin
    offset_t lane;
    data_wdata_o = '0;
    for (int i = 0; i < BYTES_PER_WORD; i++)
    begin
      lane = offset_t'(i) + offset; // Wraps mod 4
      data_wdata_o[lane*BYTE_W +: BYTE_W] = wdata_q[i*BYTE_W +: BYTE_W];
    end
  end

  // Push control on every grant
  assign txn.push          = grant;
  assign txn.ctrl.we       = we_q;
  assign txn.ctrl.size     = size_q;
  assign txn.ctrl.sign_ext = sign_ext_q;
  assign txn.ctrl.offset   = offset;
  assign txn.ctrl.last     = last_phase;

  // OBI rule: request held stable until granted
  a_req_stable : assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o) &&
      $stable(data_we_o) && $stable(data_be_o) && $stable(data_wdata_o));

endmodule

//--- lsu_rsp_if.sv
`timescale 1ns/1ps

// Bus responses paired with the control of the oldest transfer
interface lsu_rsp_if import lsu_pkg::*; ();

  logic      valid; // Copy of data_rvalid_i
  data_t     rdata; // Raw bus read data
  logic      err;   // Bus error of this transfer
  lsu_ctrl_t ctrl;  // Control of the oldest outstanding transfer

  modport src (
    output valid,
    output rdata,
    output err,
    output ctrl
  );

  modport dst (
    input valid,
    input rdata,
    input err,
    input ctrl
  );

endinterface

//--- lsu_top.f
lsu_pkg.sv
lsu_txn_if.sv
lsu_rsp_if.sv
lsu_req_stage.sv
lsu_txn_tracker.sv
lsu_rdata_align.sv
lsu_top.sv
tb_lsu_top.sv

//--- lsu_top.sv
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; #(
  parameter int unsigned DEPTH = 2 // Max outstanding bus transfers
) (
  input  logic      clk,
  input  logic      rst_n,
  // Request side
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  logic      req_we_i,
  input  lsu_size_e req_size_i,
  input  logic      req_sign_ext_i,
  input  addr_t     req_addr_i,
  input  data_t     req_wdata_i,
  // OBI data bus
  output logic      data_req_o,
  input  logic      data_gnt_i,
  output addr_t     data_addr_o,
  output logic      data_we_o,
  output be_t       data_be_o,
  output data_t     data_wdata_o,
  input  logic      data_rvalid_i,
  input  data_t     data_rdata_i,
  input  logic      data_err_i,
  // Response side
  output logic      resp_valid_o,
  output data_t     resp_rdata_o,
  output logic      resp_err_o,
  output logic      busy_o
);

  lsu_txn_if txn ();
  lsu_rsp_if rsp ();

  lsu_req_stage u_req_stage (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_we_i       (req_we_i),
    .req_size_i     (req_size_i),
    .req_sign_ext_i (req_sign_ext_i),
    .req_addr_i     (req_addr_i),
    .req_wdata_i    (req_wdata_i),
    .data_req_o     (data_req_o),
    .data_gnt_i     (data_gnt_i),
    .data_addr_o    (data_addr_o),
    .data_we_o      (data_we_o),
    .data_be_o      (data_be_o),
    .data_wdata_o   (data_wdata_o),
    .txn            (txn)
  );

  lsu_txn_tracker #(
    .DEPTH (DEPTH)
  ) u_txn_tracker (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .data_err_i    (data_err_i),
    .busy_o        (busy_o),
    .txn           (txn),
    .rsp           (rsp)
  );

  lsu_rdata_align u_rdata_align (
    .clk          (clk),
    .rst_n        (rst_n),
    .resp_valid_o (resp_valid_o),
    .resp_rdata_o (resp_rdata_o),
    .resp_err_o   (resp_err_o),
    .rsp          (rsp)
  );

endmodule

//--- lsu_txn_if.sv
`timescale 1ns/1ps

// Granted transfers from the request stage into the tracker
interface lsu_txn_if import lsu_pkg::*; ();

  logic      push; // Transfer granted this cycle
  lsu_ctrl_t ctrl; // Control of the granted transfer
  logic      room; // Tracker can take one more transfer

  modport src (
    output push,
    output ctrl,
    input  room
  );

  modport dst (
    input  push,
    input  ctrl,
    output room
  );

endinterface

//--- lsu_txn_tracker.sv
`timescale 1ns/1ps

module lsu_txn_tracker import lsu_pkg::*; #(
  parameter int unsigned DEPTH = 2
) (
  input  logic   clk,
  input  logic   rst_n,
  // Bus responses
  input  logic   data_rvalid_i,
  input  data_t  data_rdata_i,
  input  logic   data_err_i,
  output logic   busy_o,
  lsu_txn_if.dst txn,
  lsu_rsp_if.src rsp
);

  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [CNT_W-1:0] cnt_q;          // Outstanding transfers
  logic [CNT_W-1:0] cnt_after_rsp;  // Count once this cycle's rvalid retires
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  lsu_ctrl_t        ctrl_q [DEPTH]; // In-order control queue

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  ////////////////////
  // Counter
  ////////////////////

  assign cnt_after_rsp = cnt_q - CNT_W'(data_rvalid_i);
  assign txn.room      = cnt_after_rsp < CNT_W'(DEPTH);

  // Up on push, down on rvalid, both may happen together
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt_q    <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else
    begin
      cnt_q <= cnt_after_rsp + CNT_W'(txn.push);
      if (txn.push)
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (data_rvalid_i)
        rd_ptr_q <= ptr_inc(rd_ptr_q);
    end
  end

  // When full, the write lands on the head being read this cycle
  always_ff @(posedge clk)
  begin
    if (txn.push)
      ctrl_q[wr_ptr_q] <= txn.ctrl;
  end

  // Pair response with oldest entry
  assign rsp.valid = data_rvalid_i;
  assign rsp.rdata = data_rdata_i;
  assign rsp.err   = data_err_i;
  assign rsp.ctrl  = ctrl_q[rd_ptr_q];

  assign busy_o = cnt_q != '0;

  // Every rvalid must belong to a granted transfer
  a_no_orphan_rvalid : assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> cnt_q != '0);

  // Room gating in the request stage keeps the count bounded
  a_cnt_bound : assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= CNT_W'(DEPTH));

endmodule

//--- tb_lsu_top.sv
`timescale 1ns/1ps

module tb_lsu_top import lsu_pkg::*; ();

  localparam int unsigned DEPTH      = 2;
  localparam int          WAIT_LIMIT = 200; // Cycles before a wait gives up

  logic      clk;
  logic      rst_n;
  logic      req_valid_i;
  logic      req_ready_o;
  logic      req_we_i;
  lsu_size_e req_size_i;
  logic      req_sign_ext_i;
  addr_t     req_addr_i;
  data_t     req_wdata_i;
  logic      req_inj_err;            // Bus model flags the first phase of this access
  logic      data_req_o;
  logic      data_gnt_i    = 1'b0;
  addr_t     data_addr_o;
  logic      data_we_o;
  be_t       data_be_o;
  data_t     data_wdata_o;
  logic      data_rvalid_i = 1'b0;
  data_t     data_rdata_i  = '0;
  logic      data_err_i    = 1'b0;
  logic      resp_valid_o;
  data_t     resp_rdata_o;
  logic      resp_err_o;
  logic      busy_o;

  logic [7:0] bus_mem [addr_t]; // Memory behind the bus
  logic [7:0] shadow  [addr_t]; // Reference copy, written at acceptance
  data_t      rv_data_q [$];    // Pending responses, in grant order
  logic       rv_err_q  [$];
  int         rv_due_q  [$];    // Cycle at which rvalid goes out
  int         cyc      = 0;
  int         last_due = 0;
  int         gnt_wait = 0;     // Cycles left before the next grant
  logic       err_arm  = 1'b0;
  int         outst    = 0;     // Granted transfers awaiting rvalid
  logic       seen_req = 1'b0;

  // Expected bus phases and responses
  addr_t ph_addr_q [$];
  be_t   ph_be_q   [$];
  data_t ph_wdata_q [$];
  logic  ph_we_q   [$];
  data_t exp_rdata_q [$];
  logic  exp_err_q [$];
  int    ph_cnt    = 0;
  addr_t ph_addr   = '0;
  be_t   ph_be     = '0;
  data_t ph_wdata  = '0;
  logic  ph_we     = 1'b0;
  int    exp_cnt   = 0;
  data_t exp_rdata = '0;
  logic  exp_err   = 1'b0;

  lsu_top #(
    .DEPTH (DEPTH)
  ) u_lsu_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_we_i       (req_we_i),
    .req_size_i     (req_size_i),
    .req_sign_ext_i (req_sign_ext_i),
    .req_addr_i     (req_addr_i),
    .req_wdata_i    (req_wdata_i),
    .data_req_o     (data_req_o),
    .data_gnt_i     (data_gnt_i),
    .data_addr_o    (data_addr_o),
    .data_we_o      (data_we_o),
    .data_be_o      (data_be_o),
    .data_wdata_o   (data_wdata_o),
    .data_rvalid_i  (data_rvalid_i),
    .data_rdata_i   (data_rdata_i),
    .data_err_i     (data_err_i),
    .resp_valid_o   (resp_valid_o),
    .resp_rdata_o   (resp_rdata_o),
    .resp_err_o     (resp_err_o),
    .busy_o         (busy_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  task automatic stop_run(input string why);
    $display("%s at %0t", why, $time);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string sig, input data_t exp, input data_t got);
    $display("ERROR t=%0t %s exp=%h got=%h", $time, sig, exp, got);
    stop_run($sformatf("wrong value on %s", sig));
  endtask

  // Untouched bytes read a pattern of the whole address
  function automatic logic [7:0] fill_byte(input addr_t a);
    return a[31:24] ^ a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'hA5;
  endfunction

  function automatic logic [7:0] shadow_byte(input addr_t a);
    return shadow.exists(a) ? shadow[a] : fill_byte(a);
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  // Phases and result of the request accepted on this edge
  task automatic predict_access();
    offset_t off;
    int      nb;
    logic    split;
    be_t     be1;
    be_t     be2;
    data_t   rot;
    data_t   val;
    off   = req_addr_i[1:0];
    nb    = (req_size_i == LSU_BYTE) ? 1 : (req_size_i == LSU_HALF) ? 2 : 4;
    split = ((req_size_i == LSU_WORD) && (off != 2'd0)) ||
            ((req_size_i == LSU_HALF) && (off == 2'd3));
    case (req_size_i)
      LSU_BYTE: be1 = 4'b0001 << off;
      LSU_HALF: be1 = (off == 2'd3) ? 4'b1000 : (4'b0011 << off);
      default:  be1 = 4'b1111 << off;             // Lanes off..3
    endcase
    be2 = (req_size_i == LSU_HALF) ? 4'b0001 : ~be1; // Lanes below off, next word
    rot = '0;
    for (int i = 0; i < 4; i++)
      rot[((i + off) % 4) * 8 +: 8] = req_wdata_i[i*8 +: 8];
    ph_addr_q.push_back(req_addr_i);
    ph_be_q.push_back(be1);
    ph_wdata_q.push_back(rot);
    ph_we_q.push_back(req_we_i);
    if (split)
    begin
      ph_addr_q.push_back({req_addr_i[31:2], 2'b00} + 32'd4);
      ph_be_q.push_back(be2);
      ph_wdata_q.push_back(rot); // Same rotated word
      ph_we_q.push_back(req_we_i);
    end
    val = '0;
    for (int i = 0; i < nb; i++)
    begin
      if (req_we_i)
        shadow[req_addr_i + i] = req_wdata_i[i*8 +: 8];
      else
        val[i*8 +: 8] = shadow_byte(req_addr_i + i);
    end
    if (!req_we_i && req_sign_ext_i && val[nb*8-1])
      for (int i = nb * 8; i < 32; i++)
        val[i] = 1'b1;
    exp_rdata_q.push_back(val); // Stores expect zero
    exp_err_q.push_back(req_inj_err);
  endtask

  ////////////////////
  // Bus model
  ////////////////////

  always @(posedge clk)
  begin : bus_model
    addr_t base;
    data_t word;
    int    due;
    outst = outst + int'(data_req_o && data_gnt_i) - int'(data_rvalid_i);
    if (data_req_o && data_gnt_i)
    begin
      base = {data_addr_o[31:2], 2'b00};
      word = '0;
      for (int l = 0; l < 4; l++)
      begin
        if (data_we_o && data_be_o[l])
          bus_mem[base + l] = data_wdata_o[l*8 +: 8]; // Only enabled lanes
        word[l*8 +: 8] = bus_mem.exists(base + l) ? bus_mem[base + l] : fill_byte(base + l);
      end
      due = cyc + $urandom_range(1, 3);
      if (due <= last_due)
        due = last_due + 1; // In order, one rvalid per cycle
      last_due = due;
      rv_data_q.push_back(word);
      rv_err_q.push_back(err_arm);
      rv_due_q.push_back(due);
      err_arm  = 1'b0;
      gnt_wait = $urandom_range(0, 2);
      if (ph_cnt != 0)
      begin
        void'(ph_addr_q.pop_front());
        void'(ph_be_q.pop_front());
        void'(ph_wdata_q.pop_front());
        void'(ph_we_q.pop_front());
      end
    end
    else if (data_req_o && gnt_wait > 0)
      gnt_wait--;
    if (resp_valid_o && exp_cnt != 0)
    begin
      void'(exp_rdata_q.pop_front());
      void'(exp_err_q.pop_front());
    end
    if (req_valid_i && req_ready_o)
    begin
      predict_access();
      seen_req = 1'b1;
      err_arm  = req_inj_err; // Error goes on the first grant
    end
    ph_cnt    = ph_addr_q.size();
    ph_addr   = (ph_cnt != 0) ? ph_addr_q[0] : '0;
    ph_be     = (ph_cnt != 0) ? ph_be_q[0] : '0;
    ph_wdata  = (ph_cnt != 0) ? ph_wdata_q[0] : '0;
    ph_we     = (ph_cnt != 0) ? ph_we_q[0] : 1'b0;
    exp_cnt   = exp_rdata_q.size();
    exp_rdata = (exp_cnt != 0) ? exp_rdata_q[0] : '0;
    exp_err   = (exp_cnt != 0) ? exp_err_q[0] : 1'b0;
    cyc++;
  end

  // Grant and rvalid change on the falling edge
  always @(negedge clk)
  begin
    data_gnt_i = (gnt_wait == 0);
    if (rv_due_q.size() != 0 && rv_due_q[0] <= cyc)
    begin
      data_rvalid_i = 1'b1;
      data_rdata_i  = rv_data_q.pop_front();
      data_err_i    = rv_err_q.pop_front();
      void'(rv_due_q.pop_front());
    end
    else
    begin
      data_rvalid_i = 1'b0;
      data_rdata_i  = '0;
      data_err_i    = 1'b0;
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  a_reset_idle : assert property (@(posedge clk) disable iff (!rst_n)
    !seen_req |-> !data_req_o && !resp_valid_o && !busy_o && req_ready_o)
    else stop_run("outputs left their reset values before the first request");

  a_grant_expected : assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o && data_gnt_i |-> ph_cnt != 0)
    else stop_run("bus transfer granted that no access asked for");

  a_phases_done : assert property (@(posedge clk) disable iff (!rst_n)
    req_valid_i && req_ready_o |-> ph_cnt == 0)
    else stop_run("request accepted before all phases of the last access were granted");

  a_addr : assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o && data_gnt_i && ph_cnt != 0 |-> data_addr_o == ph_addr)
    else report_mismatch("data_addr_o", $sampled(ph_addr), $sampled(data_addr_o));

  a_be : assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o && data_gnt_i && ph_cnt != 0 |-> data_be_o == ph_be)
    else report_mismatch("data_be_o", $sampled(ph_be), $sampled(data_be_o));

  a_we : assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o && data_gnt_i && ph_cnt != 0 |-> data_we_o == ph_we)
    else report_mismatch("data_we_o", $sampled(ph_we), $sampled(data_we_o));

  a_wdata : assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o && data_gnt_i && ph_cnt != 0 && ph_we |-> data_wdata_o == ph_wdata)
    else report_mismatch("data_wdata_o", $sampled(ph_wdata), $sampled(data_wdata_o));

  a_outstanding : assert property (@(posedge clk) disable iff (!rst_n)
    outst <= int'(DEPTH))
    else stop_run("more bus transfers outstanding than DEPTH allows");

  // Busy follows the count of granted transfers still waiting for rvalid
  a_busy : assert property (@(posedge clk) disable iff (!rst_n)
    busy_o == (outst != 0))
    else report_mismatch("busy_o", $sampled(outst != 0), $sampled(busy_o));

  a_resp_expected : assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid_o |-> exp_cnt != 0)
    else stop_run("response strobe without an accepted request");

  a_rdata : assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid_o && exp_cnt != 0 |-> resp_rdata_o == exp_rdata)
    else report_mismatch("resp_rdata_o", $sampled(exp_rdata), $sampled(resp_rdata_o));

  a_err : assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid_o && exp_cnt != 0 |-> resp_err_o == exp_err)
    else report_mismatch("resp_err_o", $sampled(exp_err), $sampled(resp_err_o));

  a_err_idle : assert property (@(posedge clk) disable iff (!rst_n)
    !resp_valid_o |-> !resp_err_o)
    else stop_run("resp_err_o high outside a response");

  ////////////////////
  // Stimulus
  ////////////////////

  // Called at a falling edge, returns at the falling edge after acceptance
  task automatic issue_req(input logic we, input lsu_size_e size, input logic sext,
                           input addr_t addr, input data_t wdata, input logic inj);
    int waited;
    req_valid_i    = 1'b1;
    req_we_i       = we;
    req_size_i     = size;
    req_sign_ext_i = sext;
    req_addr_i     = addr;
    req_wdata_i    = wdata;
    req_inj_err    = inj;
    waited = 0;
    while (!req_ready_o)
    begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT)
        stop_run("request was not accepted in time");
    end
    @(negedge clk); // Taken on the edge just passed
    req_valid_i = 1'b0;
    req_inj_err = 1'b0;
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while (exp_cnt != 0 || busy_o)
    begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT)
        stop_run("outstanding accesses did not complete in time");
    end
  endtask

  initial
  begin
    void'($urandom(86));
    rst_n          = 1'b0;
    req_valid_i    = 1'b0;
    req_we_i       = 1'b0;
    req_size_i     = LSU_BYTE;
    req_sign_ext_i = 1'b0;
    req_addr_i     = '0;
    req_wdata_i    = '0;
    req_inj_err    = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    repeat (3) @(negedge clk); // Idle, reset values must hold
    // Aligned stores, then loads with and without extension
    issue_req(1'b1, LSU_WORD, 1'b0, 32'h100, 32'h8765_43A1, 1'b0);
    issue_req(1'b1, LSU_HALF, 1'b0, 32'h106, 32'h0000_C3F0, 1'b0);
    issue_req(1'b1, LSU_BYTE, 1'b0, 32'h10B, 32'h0000_009C, 1'b0);
    issue_req(1'b0, LSU_WORD, 1'b0, 32'h100, '0, 1'b0);
    issue_req(1'b0, LSU_HALF, 1'b1, 32'h106, '0, 1'b0);
    issue_req(1'b0, LSU_HALF, 1'b0, 32'h106, '0, 1'b0);
    issue_req(1'b0, LSU_BYTE, 1'b1, 32'h10B, '0, 1'b0);
    issue_req(1'b0, LSU_BYTE, 1'b0, 32'h10B, '0, 1'b0);
    issue_req(1'b0, LSU_HALF, 1'b1, 32'h100, '0, 1'b0);
    issue_req(1'b0, LSU_BYTE, 1'b1, 32'h103, '0, 1'b0);
    // Misaligned word at offsets 1..3, halfword across a word
    issue_req(1'b1, LSU_WORD, 1'b0, 32'h111, 32'h1122_3344, 1'b0);
    issue_req(1'b1, LSU_WORD, 1'b0, 32'h122, 32'hA5B6_C7D8, 1'b0);
    issue_req(1'b1, LSU_WORD, 1'b0, 32'h133, 32'hF00D_BEEF, 1'b0);
    issue_req(1'b1, LSU_HALF, 1'b0, 32'h143, 32'h0000_80FE, 1'b0);
    issue_req(1'b0, LSU_WORD, 1'b0, 32'h111, '0, 1'b0);
    issue_req(1'b0, LSU_WORD, 1'b0, 32'h122, '0, 1'b0);
    issue_req(1'b0, LSU_WORD, 1'b0, 32'h133, '0, 1'b0);
    issue_req(1'b0, LSU_HALF, 1'b1, 32'h143, '0, 1'b0);
    issue_req(1'b0, LSU_HALF, 1'b0, 32'h143, '0, 1'b0);
    issue_req(1'b0, LSU_WORD, 1'b0, 32'h145, '0, 1'b0); // Fill pattern only
    issue_req(1'b0, LSU_HALF, 1'b1, 32'h157, '0, 1'b0);
    // Bus errors, first phase of a split load and one aligned load
    issue_req(1'b0, LSU_WORD, 1'b0, 32'h112, '0, 1'b1);
    issue_req(1'b0, LSU_WORD, 1'b0, 32'h120, '0, 1'b1);
    issue_req(1'b0, LSU_WORD, 1'b0, 32'h121, '0, 1'b0); // Error must not stick
    // Back-to-back random traffic
    for (int n = 0; n < 60; n++)
      issue_req(1'($urandom_range(0, 1)), lsu_size_e'($urandom_range(0, 2)),
                1'($urandom_range(0, 1)), 32'h200 + $urandom_range(0, 63),
                $urandom(), 1'b0);
    wait_idle();
    if (exp_cnt == 0 && ph_cnt == 0)
    begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
    else
      stop_run("accesses left without a response at the end");
  end

endmodule
